// ==== design/udp_port_pkg.sv ====
package udp_port_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  frame_word_t;   // Bit 8 marks end of frame
    typedef logic [47:0] mac_address_t;
    typedef logic [31:0] ipv4_address_t;
    typedef logic [15:0] word16_t;

    typedef enum logic [2:0] {
        IDLE,
        SUM_HEADER,
        WAIT_SUM,
        SEND_HEADER,
        SEND_PAYLOAD,
        SEND_PAD,
        SEND_FCS
    } frame_state_t;

    //////////////////////////////////////////////////
    // Frame layout
    localparam word16_t ETHERNET_HEADER_BYTES = 16'd14;
    localparam word16_t IPV4_HEADER_BYTES     = 16'd20;
    localparam word16_t UDP_HEADER_BYTES      = 16'd8;
    localparam word16_t FRAME_HEADER_BYTES    = 16'd42;
    localparam word16_t MIN_PAYLOAD_BYTES     = 16'd18;  // Pads frame to 60 bytes
    localparam word16_t FCS_BYTES             = 16'd4;

    //////////////////////////////////////////////////
    // Header field values
    localparam word16_t ETHERTYPE_IPV4           = 16'h0800;
    localparam byte_t   IPV4_VERSION_IHL         = 8'h45;
    localparam byte_t   IPV4_TIME_TO_LIVE        = 8'd64;
    localparam byte_t   IP_PROTOCOL_UDP          = 8'd17;
    localparam word16_t IPV4_FLAGS_DONT_FRAGMENT = 16'h4000;
    localparam word16_t IPV4_CHECKSUM_OFFSET     = 16'd24;

    localparam logic [31:0] CRC32_POLYNOMIAL = 32'hEDB88320;
    localparam logic [31:0] CRC32_INITIAL    = 32'hFFFFFFFF;

endpackage

// ==== design/payload_buffer.sv ====
`timescale 1ns/1ps

module payload_buffer #(
    parameter int BUFFER_DEPTH = 1024
)(
    input  logic                        clock,
    input  logic                        reset,
    input  udp_port_pkg::byte_t         payload_data,
    input  logic                        payload_valid,
    input  logic                        payload_last,
    input  logic                        busy,
    input  udp_port_pkg::word16_t       buffer_read_address,
    output udp_port_pkg::byte_t         buffer_read_data,
    output udp_port_pkg::word16_t       payload_length,
    output logic                        frame_start
);

    localparam int ADDRESS_WIDTH = $clog2(BUFFER_DEPTH);

    udp_port_pkg::byte_t    memory [BUFFER_DEPTH];
    logic [ADDRESS_WIDTH:0] write_count;
    logic                   accept;
    logic                   full;

    assign accept = payload_valid && !busy;
    assign full   = (write_count == BUFFER_DEPTH);

    always_ff @(posedge clock) begin
        if (reset) begin
            write_count <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= accept && payload_last;
            if (frame_start)
                write_count <= '0;  // Next frame starts at address zero
            else if (accept && !full)
                write_count <= write_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept && !full)
            memory[write_count[ADDRESS_WIDTH-1:0]] <= payload_data;
        if (accept && payload_last)
            payload_length <= udp_port_pkg::word16_t'(write_count + (ADDRESS_WIDTH+1)'(!full));
    end

    assign buffer_read_data = memory[buffer_read_address[ADDRESS_WIDTH-1:0]];

    // A started frame keeps the port busy
    assert property (@(posedge clock) disable iff (reset) frame_start |=> busy);

endmodule

// ==== design/byte_counter.sv ====
`timescale 1ns/1ps

module byte_counter (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    enable,
    input  udp_port_pkg::word16_t   limit,
    output udp_port_pkg::word16_t   count,
    output logic                    last
);

    always_ff @(posedge clock) begin
        if (reset || clear)
            count <= '0;
        else if (enable)
            count <= count + 1'b1;
    end

    assign last = (count == limit - 1'b1);

    // Sequencer must clear before the section overruns
    assert property (@(posedge clock) disable iff (reset) enable |-> count < limit);

endmodule

// ==== design/internet_checksum_calculator.sv ====
`timescale 1ns/1ps

module internet_checksum_calculator (
    input  logic                    clock,
    input  logic                    reset,
    input  udp_port_pkg::byte_t     data,
    input  logic                    data_enable,
    input  logic                    data_last,
    output udp_port_pkg::word16_t   result,
    output logic                    result_valid
);

    udp_port_pkg::word16_t accumulator;
    udp_port_pkg::word16_t pair_word;
    udp_port_pkg::word16_t folded_sum;
    udp_port_pkg::byte_t   high_byte;
    logic                  low_phase;   // Next byte completes a word
    logic [16:0]           word_sum;
    logic                  add_word;

    // Odd trailing byte is padded with zero
    assign pair_word  = low_phase ? {high_byte, data} : {data, 8'h00};
    assign add_word   = data_enable && (low_phase || data_last);
    assign word_sum   = accumulator + pair_word;
    assign folded_sum = word_sum[15:0] + word_sum[16];  // End-around carry

    always_ff @(posedge clock) begin
        if (reset) begin
            accumulator  <= '0;
            low_phase    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= data_enable && data_last;
            if (data_enable && data_last) begin
                accumulator <= '0;
                low_phase   <= 1'b0;
            end else if (data_enable) begin
                low_phase <= !low_phase;
                if (add_word)
                    accumulator <= folded_sum;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (data_enable && !low_phase)
            high_byte <= data;
        if (data_enable && data_last)
            result <= ~folded_sum;
    end

endmodule

// ==== design/frame_check_sequence_generator.sv ====
`timescale 1ns/1ps

module frame_check_sequence_generator (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    clear,
    input  udp_port_pkg::byte_t     data,
    input  logic                    data_enable,
    output logic [31:0]             crc
);

    logic [31:0] crc_register;
    logic [31:0] crc_next;

    // Reflected CRC, LSB of each byte first
    always_comb begin
        crc_next = crc_register ^ {24'h000000, data};
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            if (crc_next[0])
                crc_next = (crc_next >> 1) ^ udp_port_pkg::CRC32_POLYNOMIAL;
            else
                crc_next = crc_next >> 1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear)
            crc_register <= udp_port_pkg::CRC32_INITIAL;
        else if (data_enable)
            crc_register <= crc_next;
    end

    assign crc = ~crc_register;

endmodule

// ==== design/frame_header_builder.sv ====
`timescale 1ns/1ps

module frame_header_builder (
    input  udp_port_pkg::mac_address_t  mac_source,
    input  udp_port_pkg::mac_address_t  mac_destination,
    input  udp_port_pkg::ipv4_address_t ipv4_source,
    input  udp_port_pkg::ipv4_address_t ipv4_destination,
    input  udp_port_pkg::word16_t       udp_source,
    input  udp_port_pkg::word16_t       udp_destination,
    input  udp_port_pkg::word16_t       payload_length,
    input  udp_port_pkg::word16_t       ipv4_checksum,
    input  udp_port_pkg::word16_t       header_offset,
    output udp_port_pkg::byte_t         header_byte
);

    localparam int HEADER_BITS = udp_port_pkg::FRAME_HEADER_BYTES * 8;

    udp_port_pkg::word16_t  ipv4_total_length;
    udp_port_pkg::word16_t  udp_length;
    udp_port_pkg::word16_t  byte_index;
    logic [HEADER_BITS-1:0] header_bits;

    assign udp_length        = udp_port_pkg::UDP_HEADER_BYTES + payload_length;
    assign ipv4_total_length = udp_port_pkg::IPV4_HEADER_BYTES + udp_length;

    // Offset 0 sits in the top byte
    assign header_bits = {
        mac_destination,
        mac_source,
        udp_port_pkg::ETHERTYPE_IPV4,
        udp_port_pkg::IPV4_VERSION_IHL,
        8'h00,                                  // TOS
        ipv4_total_length,
        16'h0000,                               // Identification
        udp_port_pkg::IPV4_FLAGS_DONT_FRAGMENT,
        udp_port_pkg::IPV4_TIME_TO_LIVE,
        udp_port_pkg::IP_PROTOCOL_UDP,
        ipv4_checksum,
        ipv4_source,
        ipv4_destination,
        udp_source,
        udp_destination,
        udp_length,
        16'h0000                                // UDP checksum unused
    };

    assign byte_index = udp_port_pkg::FRAME_HEADER_BYTES - 1'b1 - header_offset;

    always_comb begin
        if (header_offset < udp_port_pkg::FRAME_HEADER_BYTES)
            header_byte = udp_port_pkg::byte_t'(header_bits >> {byte_index, 3'b000});
        else
            header_byte = '0;
    end

endmodule

// ==== design/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        frame_start,
    input  udp_port_pkg::word16_t       payload_length,
    input  udp_port_pkg::byte_t         buffer_read_data,
    input  udp_port_pkg::byte_t         header_byte,
    input  udp_port_pkg::word16_t       count,
    input  logic                        last,
    input  udp_port_pkg::word16_t       checksum_result,
    input  logic                        checksum_result_valid,
    input  logic [31:0]                 crc,
    output udp_port_pkg::word16_t       buffer_read_address,
    output udp_port_pkg::word16_t       header_offset,
    output logic                        counter_clear,
    output logic                        counter_enable,
    output udp_port_pkg::word16_t       counter_limit,
    output udp_port_pkg::byte_t         checksum_data,
    output logic                        checksum_data_enable,
    output logic                        checksum_data_last,
    output udp_port_pkg::byte_t         crc_data,
    output logic                        crc_data_enable,
    output logic                        crc_clear,
    output udp_port_pkg::word16_t       ipv4_checksum,
    output udp_port_pkg::frame_word_t   frame_data,
    output logic                        frame_valid,
    output logic                        busy
);

    udp_port_pkg::frame_state_t state;
    udp_port_pkg::frame_state_t state_next;
    udp_port_pkg::byte_t        frame_byte;
    logic                       short_payload;
    logic                       checksum_field;

    assign short_payload  = payload_length < udp_port_pkg::MIN_PAYLOAD_BYTES;
    assign checksum_field = (header_offset == udp_port_pkg::IPV4_CHECKSUM_OFFSET) ||
                            (header_offset == udp_port_pkg::IPV4_CHECKSUM_OFFSET + 1'b1);

    //////////////////////////////////////////////////
    // State machine
    always_comb begin
        state_next    = state;
        counter_limit = udp_port_pkg::FCS_BYTES;
        case (state)
            udp_port_pkg::IDLE:
                if (frame_start) state_next = udp_port_pkg::SUM_HEADER;
            udp_port_pkg::SUM_HEADER: begin
                counter_limit = udp_port_pkg::IPV4_HEADER_BYTES;
                if (last) state_next = udp_port_pkg::WAIT_SUM;
            end
            udp_port_pkg::WAIT_SUM:
                if (checksum_result_valid) state_next = udp_port_pkg::SEND_HEADER;
            udp_port_pkg::SEND_HEADER: begin
                counter_limit = udp_port_pkg::FRAME_HEADER_BYTES;
                if (last) state_next = udp_port_pkg::SEND_PAYLOAD;
            end
            udp_port_pkg::SEND_PAYLOAD: begin
                counter_limit = payload_length;
                if (last)
                    state_next = short_payload ? udp_port_pkg::SEND_PAD : udp_port_pkg::SEND_FCS;
            end
            udp_port_pkg::SEND_PAD: begin
                counter_limit = udp_port_pkg::MIN_PAYLOAD_BYTES - payload_length;
                if (last) state_next = udp_port_pkg::SEND_FCS;
            end
            udp_port_pkg::SEND_FCS:
                if (last) state_next = udp_port_pkg::IDLE;
            default:
                state_next = udp_port_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= udp_port_pkg::IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clock) begin
        if (state == udp_port_pkg::WAIT_SUM && checksum_result_valid)
            ipv4_checksum <= checksum_result;
    end

    assign counter_enable = !(state inside {udp_port_pkg::IDLE, udp_port_pkg::WAIT_SUM});
    assign counter_clear  = !counter_enable || last;

    assign header_offset = (state == udp_port_pkg::SUM_HEADER)
                         ? udp_port_pkg::ETHERNET_HEADER_BYTES + count : count;
    assign buffer_read_address = count;

    // Checksum field itself is skipped, pairing stays aligned
    assign checksum_data        = header_byte;
    assign checksum_data_enable = (state == udp_port_pkg::SUM_HEADER) && !checksum_field;
    assign checksum_data_last   = (state == udp_port_pkg::SUM_HEADER) && last;

    //////////////////////////////////////////////////
    // Output stream
    always_comb begin
        case (state)
            udp_port_pkg::SEND_HEADER:  frame_byte = header_byte;
            udp_port_pkg::SEND_PAYLOAD: frame_byte = buffer_read_data;
            udp_port_pkg::SEND_FCS:     frame_byte = udp_port_pkg::byte_t'(crc >> {count[1:0], 3'b000});
            default:                    frame_byte = '0;  // Padding
        endcase
    end

    assign frame_valid = state inside {udp_port_pkg::SEND_HEADER, udp_port_pkg::SEND_PAYLOAD,
                                       udp_port_pkg::SEND_PAD, udp_port_pkg::SEND_FCS};
    assign frame_data  = {(state == udp_port_pkg::SEND_FCS) && last, frame_byte};

    assign crc_data        = frame_byte;
    assign crc_data_enable = frame_valid && (state != udp_port_pkg::SEND_FCS);
    assign crc_clear       = (state == udp_port_pkg::IDLE);

    assign busy = (state != udp_port_pkg::IDLE) || frame_start;

    // Header begins at offset zero
    assert property (@(posedge clock) disable iff (reset)
        $rose(frame_valid) |-> count == '0);
    assert property (@(posedge clock) disable iff (reset)
        state == udp_port_pkg::WAIT_SUM |-> checksum_result_valid);

endmodule

// ==== design/udp_transmit_port.sv ====
`timescale 1ns/1ps

module udp_transmit_port #(
    parameter int BUFFER_DEPTH = 1024
)(
    input  logic                        clock,
    input  logic                        reset,
    input  udp_port_pkg::mac_address_t  mac_source,
    input  udp_port_pkg::mac_address_t  mac_destination,
    input  udp_port_pkg::ipv4_address_t ipv4_source,
    input  udp_port_pkg::ipv4_address_t ipv4_destination,
    input  udp_port_pkg::word16_t       udp_source,
    input  udp_port_pkg::word16_t       udp_destination,
    input  udp_port_pkg::byte_t         payload_data,
    input  logic                        payload_valid,
    input  logic                        payload_last,
    output udp_port_pkg::frame_word_t   frame_data,
    output logic                        frame_valid,
    output logic                        busy
);

    udp_port_pkg::word16_t buffer_read_address;
    udp_port_pkg::byte_t   buffer_read_data;
    udp_port_pkg::word16_t payload_length;
    logic                  frame_start;

    udp_port_pkg::word16_t counter_limit;
    udp_port_pkg::word16_t count;
    logic                  counter_clear;
    logic                  counter_enable;
    logic                  last;

    udp_port_pkg::byte_t   checksum_data;
    logic                  checksum_data_enable;
    logic                  checksum_data_last;
    udp_port_pkg::word16_t checksum_result;
    logic                  checksum_result_valid;

    udp_port_pkg::byte_t   crc_data;
    logic                  crc_data_enable;
    logic                  crc_clear;
    logic [31:0]           crc;

    udp_port_pkg::word16_t header_offset;
    udp_port_pkg::word16_t ipv4_checksum;
    udp_port_pkg::byte_t   header_byte;

    payload_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) payload_buffer (
        .clock(clock), .reset(reset), .payload_data(payload_data),
        .payload_valid(payload_valid), .payload_last(payload_last), .busy(busy),
        .buffer_read_address(buffer_read_address), .buffer_read_data(buffer_read_data),
        .payload_length(payload_length), .frame_start(frame_start)
    );

    byte_counter byte_counter (
        .clock(clock), .reset(reset), .clear(counter_clear), .enable(counter_enable),
        .limit(counter_limit), .count(count), .last(last)
    );

    internet_checksum_calculator ipv4_checksum_calculator (
        .clock(clock), .reset(reset), .data(checksum_data),
        .data_enable(checksum_data_enable), .data_last(checksum_data_last),
        .result(checksum_result), .result_valid(checksum_result_valid)
    );

    frame_check_sequence_generator frame_check_sequence_generator (
        .clock(clock), .reset(reset), .clear(crc_clear), .data(crc_data),
        .data_enable(crc_data_enable), .crc(crc)
    );

    frame_header_builder frame_header_builder (
        .mac_source(mac_source), .mac_destination(mac_destination),
        .ipv4_source(ipv4_source), .ipv4_destination(ipv4_destination),
        .udp_source(udp_source), .udp_destination(udp_destination),
        .payload_length(payload_length), .ipv4_checksum(ipv4_checksum),
        .header_offset(header_offset), .header_byte(header_byte)
    );

    frame_sequencer frame_sequencer (
        .clock(clock), .reset(reset), .frame_start(frame_start),
        .payload_length(payload_length), .buffer_read_data(buffer_read_data),
        .header_byte(header_byte), .count(count), .last(last),
        .checksum_result(checksum_result), .checksum_result_valid(checksum_result_valid),
        .crc(crc), .buffer_read_address(buffer_read_address), .header_offset(header_offset),
        .counter_clear(counter_clear), .counter_enable(counter_enable),
        .counter_limit(counter_limit), .checksum_data(checksum_data),
        .checksum_data_enable(checksum_data_enable), .checksum_data_last(checksum_data_last),
        .crc_data(crc_data), .crc_data_enable(crc_data_enable), .crc_clear(crc_clear),
        .ipv4_checksum(ipv4_checksum), .frame_data(frame_data),
        .frame_valid(frame_valid), .busy(busy)
    );

endmodule

// ==== tests/udp_transmit_port_tb.sv ====
`timescale 1ns/1ps

module udp_transmit_port_tb;

    localparam int    RANDOM_FRAMES   = 12;
    localparam int    TOTAL_FRAMES    = RANDOM_FRAMES + 4 + 2;
    localparam longint WATCHDOG_NS    = TOTAL_FRAMES * (110 + 30) * 10 * 2;
    localparam int    FRAME_WAIT_LIMIT = 400;
    localparam logic [47:0] MAC_SOURCE       = 48'h02_11_22_33_44_55;
    localparam logic [47:0] MAC_DESTINATION  = 48'h02_AA_BB_CC_DD_EE;
    localparam logic [31:0] IPV4_SOURCE      = 32'hC0A8_0A01;
    localparam logic [31:0] IPV4_DESTINATION = 32'hC0A8_0A64;
    localparam logic [15:0] UDP_SOURCE       = 16'd5001;
    localparam logic [15:0] UDP_DESTINATION  = 16'd6002;

    logic clock;
    logic reset;
    logic [7:0] payload_data;
    logic payload_valid;
    logic payload_last;
    udp_port_pkg::frame_word_t frame_data;
    logic frame_valid;
    logic busy;

    logic [15:0] lfsr_state = 16'd82;
    logic [7:0]  payload_bytes [0:255];
    logic [7:0]  expected_frame [0:255];
    int          expected_length;
    logic [7:0]  received_bytes [0:255];
    logic        received_end [0:255];
    int          received_count;
    int          frames_received;
    int          tests_run;
    int          tests_failed;
    int          checks_failed;
    string       test_name;

    udp_transmit_port #(.BUFFER_DEPTH(1024)) DUT (
        .clock(clock), .reset(reset),
        .mac_source(MAC_SOURCE), .mac_destination(MAC_DESTINATION),
        .ipv4_source(IPV4_SOURCE), .ipv4_destination(IPV4_DESTINATION),
        .udp_source(UDP_SOURCE), .udp_destination(UDP_DESTINATION),
        .payload_data(payload_data), .payload_valid(payload_valid),
        .payload_last(payload_last), .frame_data(frame_data),
        .frame_valid(frame_valid), .busy(busy)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Reference model

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [15:0] random_bits(input int width);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [15:0] ones_complement_add(input logic [15:0] sum,
                                                        input logic [15:0] word);
        logic [16:0] total;
        total = sum + word;
        return total[15:0] + total[16];
    endfunction

    function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] data);
        logic feedback;
        for (int b = 0; b < 8; b++) begin
            feedback = crc[0] ^ data[b];
            crc = crc >> 1;
            if (feedback)
                crc = crc ^ 32'hEDB88320;
        end
        return crc;
    endfunction

    function automatic void place_field(input int offset, input logic [47:0] value,
                                        input int width);
        for (int i = 0; i < width; i++)
            expected_frame[offset + i] = value[8 * (width - 1 - i) +: 8];  // Network order
    endfunction

    function automatic void build_reference_frame(input int payload_count);
        logic [15:0] sum;
        logic [31:0] crc;
        int padded;
        padded = (payload_count < 18) ? 18 : payload_count;
        place_field(0, MAC_DESTINATION, 6);
        place_field(6, MAC_SOURCE, 6);
        place_field(12, 48'h0800, 2);
        place_field(14, 48'h4500, 2);
        place_field(16, 48'(28 + payload_count), 2);
        place_field(18, 48'h0, 2);
        place_field(20, 48'h4000, 2);
        place_field(22, 48'h4011, 2);   // TTL 64, UDP
        place_field(24, 48'h0, 2);
        place_field(26, 48'(IPV4_SOURCE), 4);
        place_field(30, 48'(IPV4_DESTINATION), 4);
        place_field(34, 48'(UDP_SOURCE), 2);
        place_field(36, 48'(UDP_DESTINATION), 2);
        place_field(38, 48'(8 + payload_count), 2);
        place_field(40, 48'h0, 2);
        sum = '0;
        for (int i = 14; i < 34; i += 2)
            sum = ones_complement_add(sum, {expected_frame[i], expected_frame[i + 1]});
        place_field(24, 48'(~sum), 2);
        for (int i = 0; i < padded; i++)
            expected_frame[42 + i] = (i < payload_count) ? payload_bytes[i] : 8'h00;
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < 42 + padded; i++)
            crc = crc32_update(crc, expected_frame[i]);
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            expected_frame[42 + padded + i] = crc[8 * i +: 8];  // Low byte first
        expected_length = 42 + padded + 4;
    endfunction

    //////////////////////////////////////////////////
    // Monitor and comparison

    task automatic compare_frame();
        int errors;
        logic [15:0] sum;
        errors = 0;
        if (received_count != expected_length) begin
            $display("Fail %s frame length: expected %0d, actual %0d",
                     test_name, expected_length, received_count);
            errors++;
        end
        for (int i = 0; i < received_count && i < expected_length; i++) begin
            if (received_bytes[i] != expected_frame[i]) begin
                $display("Fail %s byte %0d: expected 0x%02h, actual 0x%02h",
                         test_name, i, expected_frame[i], received_bytes[i]);
                errors++;
            end
            if (received_end[i] != (i == received_count - 1)) begin
                $display("Fail %s end marker at byte %0d: expected %0b, actual %0b",
                         test_name, i, i == received_count - 1, received_end[i]);
                errors++;
            end
        end
        if (received_count >= 34) begin
            sum = '0;
            for (int i = 14; i < 34; i += 2)
                sum = ones_complement_add(sum, {received_bytes[i], received_bytes[i + 1]});
            if (sum != 16'hFFFF) begin
                $display("Fail %s IPv4 header sum: expected 0xffff, actual 0x%04h",
                         test_name, sum);
                errors++;
            end
        end
        checks_failed += errors;
        if (errors != 0)
            tests_failed++;
        $display("%s finished with %0d errors", test_name, errors);
    endtask

    always @(posedge clock) begin
        if (reset) begin
            received_count = 0;
        end else if (frame_valid) begin
            received_bytes[received_count] = frame_data[7:0];
            received_end[received_count]   = frame_data[8];
            received_count++;
        end else if (received_count > 0) begin   // Frame ended last cycle
            compare_frame();
            received_count = 0;
            frames_received <= frames_received + 1;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic send_payload(input int count, input bit drive_while_busy);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            payload_data  <= payload_bytes[i];
            payload_valid <= 1'b1;
            payload_last  <= (i == count - 1);
        end
        // These land while busy is high and must vanish
        for (int i = 0; drive_while_busy && i < 10; i++) begin
            @(posedge clock);
            payload_data  <= 8'(random_bits(8));
            payload_last  <= (i == 9);
        end
        @(posedge clock);
        payload_valid <= 1'b0;
        payload_last  <= 1'b0;
    endtask

    task automatic run_frame_test(input int count, input string name, input bit drive_while_busy);
        int frames_before;
        int cycles;
        for (int i = 0; i < count; i++)
            payload_bytes[i] = 8'(random_bits(8));
        test_name = name;
        build_reference_frame(count);
        tests_run++;
        frames_before = frames_received;
        send_payload(count, drive_while_busy);
        cycles = 0;
        while (frames_received == frames_before && cycles < FRAME_WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (frames_received == frames_before) begin
            $display("%s produced no frame within %0d cycles", name, FRAME_WAIT_LIMIT);
            checks_failed++;
            tests_failed++;
        end
        while (busy)
            @(posedge clock);
    endtask

    initial begin
        int length;
        reset           <= 1'b1;
        payload_data    <= '0;
        payload_valid   <= 1'b0;
        payload_last    <= 1'b0;
        frames_received = 0;
        tests_run       = 0;
        tests_failed    = 0;
        checks_failed   = 0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);
        tests_run++;
        if (frame_valid || busy || frame_data[8]) begin
            $display("After reset frame_valid, busy or the end marker is not low");
            checks_failed++;
            tests_failed++;
        end
        $display("reset_state finished");

        run_frame_test(1, "fixed_len_1", 1'b0);
        run_frame_test(17, "fixed_len_17", 1'b0);
        run_frame_test(18, "fixed_len_18", 1'b0);
        run_frame_test(19, "fixed_len_19", 1'b0);
        for (int k = 0; k < RANDOM_FRAMES; k++) begin
            length = random_bits(6) + 1;
            run_frame_test(length, $sformatf("random_%0d_len_%0d", k, length), 1'b0);
        end
        run_frame_test(23, "busy_writes_len_23", 1'b1);
        run_frame_test(9, "after_busy_len_9", 1'b0);

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, checks_failed);
        if (checks_failed == 0 && tests_failed == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with frames still outstanding", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== build.f ====
design/udp_port_pkg.sv
design/payload_buffer.sv
design/byte_counter.sv
design/internet_checksum_calculator.sv
design/frame_check_sequence_generator.sv
design/frame_header_builder.sv
design/frame_sequencer.sv
design/udp_transmit_port.sv
tests/udp_transmit_port_tb.sv
